// ==== verilog.f ====
+incdir+.
hazard_pkg.sv
stage_tracker.sv
operand_forward.sv
stall_control.sv
hazard_unit.sv
hazard_props.sv
tb_hazard_unit.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_hazard_unit -o sim_hazard

./obj_dir/sim_hazard > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== tb_hazard_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_hazard_unit;

    typedef struct packed {
        logic       v;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] dest;
        logic       rw, mr, br, jp, div, rdy, imem, dmem, exc;
    } step_t;

    logic clk = 1'b0;
    logic rst;
    logic d_valid, d_regwrite, d_memtoreg, d_isbranch, d_isjump, d_div_en;
    logic [4:0] d_rs, d_rt, d_dest;
    logic div_ready, imem_busy, dmem_busy, m_exc;
    logic [4:0] stall, flush;
    logic [7:0] fwd_sel;

    // Model of the E, M and W producer entries
    logic [4:0] me_rs, me_rt, me_dest, mm_dest, mw_dest;
    logic me_rw, me_mr, me_div, mm_rw, mm_mr, mw_rw;
    logic [4:0] exp_stall, exp_flush;
    logic [7:0] exp_fwd;

    step_t tbl[$];
    string names[$];
    int errors = 0;
    int seed = 67712;
    int cnt;
    logic [31:0] r;

    always #2 clk = ~clk;

    hazard_unit uut (
        .clk (clk), .rst (rst), .d_valid (d_valid), .d_rs (d_rs), .d_rt (d_rt),
        .d_dest (d_dest), .d_regwrite (d_regwrite), .d_memtoreg (d_memtoreg),
        .d_isbranch (d_isbranch), .d_isjump (d_isjump), .d_div_en (d_div_en),
        .div_ready (div_ready), .imem_busy (imem_busy), .dmem_busy (dmem_busy),
        .m_exc (m_exc), .stall (stall), .flush (flush), .fwd_sel (fwd_sel)
    );

    task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic [1:0] fwd_of(input logic [4:0] op);
        if (op == 5'd0)
            return 2'd0;
        else if (mm_rw && mm_dest == op)
            return 2'd2;
        else if (mw_rw && mw_dest == op)
            return 2'd1;
        return 2'd0;
    endfunction

    task automatic compute_expected();
        logic lu, mhit, bw;
        lu = (d_rs != 0 && me_mr && me_dest == d_rs) || (d_rt != 0 && me_mr && me_dest == d_rt)
           || (me_rs != 0 && mm_mr && mm_dest == me_rs)
           || (me_rt != 0 && mm_mr && mm_dest == me_rt);
        mhit = mm_mr && mm_dest != 0 && (mm_dest == d_rs || mm_dest == d_rt);
        bw = (d_isbranch || d_isjump) && ((d_rs != 0 && me_rw && me_dest == d_rs)
           || (d_rt != 0 && me_rw && me_dest == d_rt) || mhit);
        exp_stall = 5'b00000;
        exp_flush = 5'b00000;
        if (dmem_busy || (imem_busy && m_exc))
            exp_stall = 5'b11111;
        else if (m_exc)
            exp_flush = 5'b11110;
        else if (me_div && !div_ready)
        begin
            exp_stall = 5'b11100;
            exp_flush = 5'b00010;
        end
        else if (imem_busy || lu || bw)
        begin
            exp_stall = 5'b11000;
            exp_flush = 5'b00100;
        end
        exp_fwd = {fwd_of(me_rt), fwd_of(me_rs), fwd_of(d_rt), fwd_of(d_rs)};
    endtask

    // W first, then M, then E so each stage takes the old value ahead of it
    task automatic advance_model();
        if (!exp_stall[0])
        begin
            mw_dest = mm_dest;
            mw_rw   = mm_rw;
        end
        if (exp_flush[1])
            {mm_dest, mm_rw, mm_mr} = '0;
        else if (!exp_stall[1])
            {mm_dest, mm_rw, mm_mr} = {me_dest, me_rw, me_mr};
        if (exp_flush[2] || (!exp_stall[2] && (exp_stall[3] || !d_valid)))
            {me_rs, me_rt, me_dest, me_rw, me_mr, me_div} = '0;
        else if (!exp_stall[2])
            {me_rs, me_rt, me_dest, me_rw, me_mr, me_div} =
                {d_rs, d_rt, d_dest, d_regwrite, d_memtoreg, d_div_en};
    endtask

    task automatic apply(input step_t s, input string name);
        {d_valid, d_rs, d_rt, d_dest, d_regwrite, d_memtoreg, d_isbranch, d_isjump,
         d_div_en, div_ready, imem_busy, dmem_busy, m_exc} = s;
        #1;
        compute_expected();
        check({name, " stall"}, {3'b000, exp_stall}, {3'b000, stall});
        check({name, " flush"}, {3'b000, exp_flush}, {3'b000, flush});
        check({name, " fwd_sel"}, exp_fwd, fwd_sel);
        @(posedge clk);
        advance_model();
        #1;
    endtask

    task automatic add_step(input string n, input logic v, input logic [4:0] rs, rt, dest,
                            input logic rw, mr, br, jp, div, rdy, imem, dmem, exc);
        tbl.push_back({v, rs, rt, dest, rw, mr, br, jp, div, rdy, imem, dmem, exc});
        names.push_back(n);
    endtask

    initial
    begin
        rst = 1'b1;
        {d_valid, d_rs, d_rt, d_dest, d_regwrite, d_memtoreg, d_isbranch, d_isjump,
         d_div_en, div_ready, imem_busy, dmem_busy, m_exc} = '0;
        {me_rs, me_rt, me_dest, me_rw, me_mr, me_div} = '0;
        {mm_dest, mm_rw, mm_mr, mw_dest, mw_rw} = '0;
        repeat (15) @(posedge clk);
        #1;
        apply('0, "reset_idle");
        rst = 1'b0;

        //        name        v  rs  rt dst rw mr br jp dv rdy im dm ex
        add_step("fwd_wr",    1, 1,  2, 5,  1, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("fwd_rd",    1, 5,  0, 6,  1, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("fwd_rd2",   1, 0,  5, 0,  0, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("r0_wr",     1, 3,  3, 0,  1, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("r0_rd",     1, 0,  0, 4,  1, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("load",      1, 1,  0, 7,  1, 1, 0, 0, 0, 1, 0, 0, 0);
        add_step("load_use",  1, 7,  2, 8,  1, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("load_use2", 1, 7,  2, 8,  1, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("br_alu_wr", 1, 1,  1, 9,  1, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("br_alu",    1, 9,  0, 0,  0, 0, 1, 0, 0, 1, 0, 0, 0);
        add_step("br_alu2",   1, 9,  0, 0,  0, 0, 1, 0, 0, 1, 0, 0, 0);
        add_step("br_ld",     1, 1,  0, 10, 1, 1, 0, 0, 0, 1, 0, 0, 0);
        add_step("br_ld_nop", 0, 0,  0, 0,  0, 0, 0, 0, 0, 1, 0, 0, 0);
        add_step("br_ld_dep", 1, 10, 0, 0,  0, 0, 0, 1, 0, 1, 0, 0, 0);
        add_step("br_ld_dep2", 1, 10, 0, 11, 1, 0, 0, 1, 0, 1, 0, 0, 0);
        add_step("dmem_exc",  1, 1,  2, 11, 1, 0, 0, 0, 0, 1, 0, 1, 1);
        add_step("exc",       1, 1,  2, 11, 1, 0, 0, 0, 0, 1, 0, 0, 1);
        add_step("exc_after", 1, 11, 0, 0,  0, 0, 1, 0, 0, 1, 0, 0, 0);
        add_step("imem",      1, 1,  2, 12, 1, 0, 0, 0, 0, 1, 1, 0, 0);
        add_step("div",       1, 1,  2, 13, 1, 0, 0, 0, 1, 0, 0, 0, 0);

        foreach (tbl[i])
            apply(tbl[i], names[i]);

        repeat (4)
            apply({1'b0, 15'd0, 9'd0}, "div_wait");
        cnt = 0;
        do
        begin
            apply({1'b0, 15'd0, 5'd0, 1'b1, 3'd0}, "div_release");
            cnt++;
        end
        while (stall !== 5'b00000 && cnt < 200);
        if (cnt >= 200)
        begin
            $display("Timeout: divider stall never released");
            $display("RESULT: FAIL");
            $finish;
        end

        repeat (200)
        begin
            r = $random(seed);
            apply({r[0], 2'b00, r[3:1], 2'b00, r[6:4], 2'b00, r[9:7], r[10] | r[11], r[11],
                   r[12] & r[13], r[14] & r[15], r[16] & r[17] & r[18], r[19] | r[20],
                   3'b000}, "random");
        end

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hazard_props.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "hazard_params.svh"

module hazard_props
(
    input wire logic                            clk,
    input wire logic                            rst,
    input wire logic                            m_exc,
    input wire logic                            imem_busy,
    input wire logic                            dmem_busy,
    input wire logic [`NUM_STAGES-1:0]          stall,
    input wire logic [`NUM_STAGES-1:0]          flush,
    input wire logic [2*`NUM_OPERANDS-1:0]      fwd_sel
);

    // Tracker holds only bubbles right after reset
    a_quiet_after_reset: assert property (@(posedge clk)
        ($past(rst) && !rst && !m_exc && !imem_busy && !dmem_busy)
        |-> (stall == '0) && (flush == '0))
        else $error("stall or flush active right after reset");

    a_no_sel3: assert property (@(posedge clk) disable iff (rst)
        (fwd_sel[1:0] != 2'd3) && (fwd_sel[3:2] != 2'd3)
        && (fwd_sel[5:4] != 2'd3) && (fwd_sel[7:6] != 2'd3))
        else $error("forward select code 3 seen");

    a_stall_xor_flush: assert property (@(posedge clk) disable iff (rst)
        ((stall & flush) == '0) && !flush[0])
        else $error("stage both stalled and flushed, or W flushed");

endmodule

bind hazard_unit hazard_props u_props (
    .clk       (clk),
    .rst       (rst),
    .m_exc     (m_exc),
    .imem_busy (imem_busy),
    .dmem_busy (dmem_busy),
    .stall     (stall),
    .flush     (flush),
    .fwd_sel   (fwd_sel)
);

`default_nettype wire

// ==== hazard_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "hazard_params.svh"

module hazard_unit
    import hazard_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            d_valid,
    input  reg_addr_t                       d_rs,
    input  reg_addr_t                       d_rt,
    input  reg_addr_t                       d_dest,
    input  logic                            d_regwrite,
    input  logic                            d_memtoreg,
    input  logic                            d_isbranch,
    input  logic                            d_isjump,
    input  logic                            d_div_en,

    input  logic                            div_ready,
    input  logic                            imem_busy,
    input  logic                            dmem_busy,
    input  logic                            m_exc,

    output stage_vec_t                      stall,
    output stage_vec_t                      flush,
    output fwd_sel_t [`NUM_OPERANDS-1:0]    fwd_sel   // D rs, D rt, E rs, E rt
);

    reg_addr_t e_rs;
    reg_addr_t e_rt;
    reg_addr_t e_dest;
    reg_addr_t m_dest;
    reg_addr_t w_dest;
    logic      e_regwrite;
    logic      m_regwrite;
    logic      w_regwrite;
    logic      e_memtoreg;
    logic      m_memtoreg;
    logic      e_div_en;

    reg_addr_t [`NUM_OPERANDS-1:0] op_addr;
    reg_addr_t [`NUM_OPERANDS-1:0] ahead_dest;
    logic      [`NUM_OPERANDS-1:0] ahead_regwrite;
    logic      [`NUM_OPERANDS-1:0] ahead_memtoreg;
    logic      [`NUM_OPERANDS-1:0] load_hazard;
    logic      [`NUM_OPERANDS-1:0] write_hazard;

    // D operands look one stage ahead at E, E operands at M
    assign op_addr        = {e_rt, e_rs, d_rt, d_rs};
    assign ahead_dest     = {m_dest, m_dest, e_dest, e_dest};
    assign ahead_regwrite = {m_regwrite, m_regwrite, e_regwrite, e_regwrite};
    assign ahead_memtoreg = {m_memtoreg, m_memtoreg, e_memtoreg, e_memtoreg};

    stage_tracker u_tracker (
        .clk        (clk),
        .rst        (rst),
        .d_valid    (d_valid),
        .d_rs       (d_rs),
        .d_rt       (d_rt),
        .d_dest     (d_dest),
        .d_regwrite (d_regwrite),
        .d_memtoreg (d_memtoreg),
        .d_div_en   (d_div_en),
        .stall      (stall),
        .flush      (flush),
        .e_rs       (e_rs),
        .e_rt       (e_rt),
        .e_dest     (e_dest),
        .m_dest     (m_dest),
        .w_dest     (w_dest),
        .e_regwrite (e_regwrite),
        .m_regwrite (m_regwrite),
        .w_regwrite (w_regwrite),
        .e_memtoreg (e_memtoreg),
        .m_memtoreg (m_memtoreg),
        .e_div_en   (e_div_en)
    );

    for (genvar i = 0; i < `NUM_OPERANDS; i++)
    begin : g_fwd
        operand_forward u_fwd (
            .operand        (op_addr[i]),
            .ahead_dest     (ahead_dest[i]),
            .ahead_regwrite (ahead_regwrite[i]),
            .ahead_memtoreg (ahead_memtoreg[i]),
            .m_dest         (m_dest),
            .m_regwrite     (m_regwrite),
            .w_dest         (w_dest),
            .w_regwrite     (w_regwrite),
            .sel            (fwd_sel[i]),
            .load_hazard    (load_hazard[i]),
            .write_hazard   (write_hazard[i])
        );
    end

    stall_control u_stall (
        .load_hazard  (load_hazard),
        .write_hazard (write_hazard),
        .d_isbranch   (d_isbranch),
        .d_isjump     (d_isjump),
        .e_div_en     (e_div_en),
        .div_ready    (div_ready),
        .imem_busy    (imem_busy),
        .dmem_busy    (dmem_busy),
        .m_exc        (m_exc),
        .m_memtoreg   (m_memtoreg),
        .m_dest       (m_dest),
        .d_rs         (d_rs),
        .d_rt         (d_rt),
        .stall        (stall),
        .flush        (flush)
    );

endmodule

`default_nettype wire

// ==== stall_control.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "hazard_params.svh"

module stall_control
    import hazard_pkg::*;
(
    input  logic [`NUM_OPERANDS-1:0] load_hazard,
    input  logic [`NUM_OPERANDS-1:0] write_hazard,   // Bits 0 and 1 belong to D

    input  logic                     d_isbranch,
    input  logic                     d_isjump,
    input  logic                     e_div_en,
    input  logic                     div_ready,
    input  logic                     imem_busy,
    input  logic                     dmem_busy,
    input  logic                     m_exc,          // Exception or eret in M

    input  logic                     m_memtoreg,
    input  reg_addr_t                m_dest,
    input  reg_addr_t                d_rs,
    input  reg_addr_t                d_rt,

    output stage_vec_t               stall,
    output stage_vec_t               flush
);

    logic load_use;
    logic branch_wait;
    logic div_wait;
    logic m_load_hit;   // M holds a load of a D operand

    assign load_use   = |load_hazard;
    assign m_load_hit = m_memtoreg && (m_dest != '0) && ((m_dest == d_rs) || (m_dest == d_rt));

    // Branches resolve in D, so they need operands from E or a loaded value
    assign branch_wait = (d_isbranch || d_isjump)
                       && (write_hazard[0] || write_hazard[1] || m_load_hit);
    assign div_wait    = e_div_en && !div_ready;

    always_comb
    begin
        stall = '0;
        flush = '0;
        if (dmem_busy || (imem_busy && m_exc))
        begin
            stall = '1;                     // Freeze the whole pipe
        end
        else if (m_exc)
        begin
            flush        = '1;
            flush[STG_W] = 1'b0;
        end
        else if (div_wait)
        begin
            stall[STG_F] = 1'b1;
            stall[STG_D] = 1'b1;
            stall[STG_E] = 1'b1;
            flush[STG_M] = 1'b1;            // Divider result not yet there
        end
        else if (imem_busy || load_use || branch_wait)
        begin
            stall[STG_F] = 1'b1;
            stall[STG_D] = 1'b1;
            flush[STG_E] = 1'b1;            // Bubble into E
        end
    end

endmodule

`default_nettype wire

// ==== operand_forward.sv ====
`default_nettype none
`timescale 1ns/1ps

module operand_forward
    import hazard_pkg::*;
(
    input  reg_addr_t operand,

    input  reg_addr_t ahead_dest,       // Producer one stage ahead of the operand
    input  logic      ahead_regwrite,
    input  logic      ahead_memtoreg,

    input  reg_addr_t m_dest,
    input  logic      m_regwrite,
    input  reg_addr_t w_dest,
    input  logic      w_regwrite,

    output fwd_sel_t  sel,
    output logic      load_hazard,
    output logic      write_hazard
);

    logic live;        // r0 is hardwired, it never depends on anything
    logic ahead_hit;

    assign live      = (operand != '0);
    assign ahead_hit = live && (ahead_dest == operand);

    assign load_hazard  = ahead_hit && ahead_memtoreg;
    assign write_hazard = ahead_hit && ahead_regwrite;

    // Youngest producer wins
    always_comb
    begin
        if (live && m_regwrite && (m_dest == operand))
            sel = FWD_M;
        else if (live && w_regwrite && (w_dest == operand))
            sel = FWD_W;
        else
            sel = FWD_RF;
    end

endmodule

`default_nettype wire

// ==== stage_tracker.sv ====
`default_nettype none
`timescale 1ns/1ps

module stage_tracker
    import hazard_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       d_valid,
    input  reg_addr_t  d_rs,
    input  reg_addr_t  d_rt,
    input  reg_addr_t  d_dest,
    input  logic       d_regwrite,
    input  logic       d_memtoreg,
    input  logic       d_div_en,

    input  stage_vec_t stall,
    input  stage_vec_t flush,

    output reg_addr_t  e_rs,
    output reg_addr_t  e_rt,
    output reg_addr_t  e_dest,
    output reg_addr_t  m_dest,
    output reg_addr_t  w_dest,
    output logic       e_regwrite,
    output logic       m_regwrite,
    output logic       w_regwrite,
    output logic       e_memtoreg,
    output logic       m_memtoreg,
    output logic       e_div_en
);

    logic d_empty;   // Nothing leaves D this cycle

    assign d_empty = stall[STG_D] || !d_valid;

    // Bubbles clear the operands too, so an empty E never matches a producer
    always_ff @(posedge clk)
    begin
        if (rst || flush[STG_E] || (!stall[STG_E] && d_empty))
        begin
            e_rs       <= '0;
            e_rt       <= '0;
            e_dest     <= '0;
            e_regwrite <= 1'b0;
            e_memtoreg <= 1'b0;
            e_div_en   <= 1'b0;
        end
        else if (!stall[STG_E])
        begin
            e_rs       <= d_rs;
            e_rt       <= d_rt;
            e_dest     <= d_dest;
            e_regwrite <= d_regwrite;
            e_memtoreg <= d_memtoreg;
            e_div_en   <= d_div_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush[STG_M])
        begin
            m_dest     <= '0;
            m_regwrite <= 1'b0;
            m_memtoreg <= 1'b0;
        end
        else if (!stall[STG_M])
        begin
            m_dest     <= e_dest;
            m_regwrite <= e_regwrite;
            m_memtoreg <= e_memtoreg;
        end
    end

    // W is never flushed
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            w_dest     <= '0;
            w_regwrite <= 1'b0;
        end
        else if (!stall[STG_W])
        begin
            w_dest     <= m_dest;
            w_regwrite <= m_regwrite;
        end
    end

endmodule

`default_nettype wire

// ==== hazard_pkg.sv ====
`default_nettype none

`include "hazard_params.svh"

package hazard_pkg;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [1:0]             fwd_sel_t;
    typedef logic [`NUM_STAGES-1:0] stage_vec_t;   // {f, d, e, m, w}

    // Forward select codes
    localparam fwd_sel_t FWD_RF = 2'd0;   // Register file value
    localparam fwd_sel_t FWD_W  = 2'd1;
    localparam fwd_sel_t FWD_M  = 2'd2;

    // Bit positions inside a stage vector, f is the MSB
    localparam int STG_F = 4;
    localparam int STG_D = 3;
    localparam int STG_E = 2;
    localparam int STG_M = 1;
    localparam int STG_W = 0;

endpackage

`default_nettype wire

// ==== hazard_params.svh ====
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// Source operands checked: rs and rt in D, then rs and rt in E
`define NUM_OPERANDS 4

`define REG_ADDR_W   5   // 32 general registers

// F, D, E, M, W
`define NUM_STAGES   5

`endif
